//--- rvIsaPkg.sv
package rvIsaPkg;

    localparam int XLen = 32;
    localparam int ShamtW = $clog2(XLen);
    localparam logic [XLen-1:0] ResetPc = 32'h0000_0000;

    // Opcode bits 6 to 2 because the low two bits are always 11
    localparam logic [4:0] OpReg = 5'b01100;
    localparam logic [4:0] OpImm = 5'b00100;
    localparam logic [4:0] OpLoad = 5'b00000;
    localparam logic [4:0] OpStore = 5'b01000;
    localparam logic [4:0] OpBranch = 5'b11000;
    localparam logic [4:0] OpJal = 5'b11011;
    localparam logic [4:0] OpJalr = 5'b11001;
    localparam logic [4:0] OpLui = 5'b01101;
    localparam logic [4:0] OpAuipc = 5'b00101;
    localparam logic [4:0] OpSystem = 5'b11100;
    localparam logic [4:0] OpFence = 5'b00011;

    // Machine CSR addresses
    localparam logic [11:0] CsrMtvec = 12'h305;
    localparam logic [11:0] CsrMscratch = 12'h340;
    localparam logic [11:0] CsrMepc = 12'h341;
    localparam logic [11:0] CsrMcause = 12'h342;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;       // Also the CSR address
        logic [4:0]  rs1;       // Also the CSR immediate
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        uTypeT u;
        jTypeT j;
    } instrT;

endpackage

//--- rvCtrlPkg.sv
package rvCtrlPkg;

    // Four-bit operation codes decoded by the ALU
    typedef enum logic [3:0] {
        AluPass   = 4'b0000,
        AluAdd    = 4'b0001,
        AluSub    = 4'b0010,
        AluAnd    = 4'b0011,
        AluAndNot = 4'b0100,
        AluOr     = 4'b0101,
        AluXor    = 4'b0110,
        AluSll    = 4'b0111,
        AluSrl    = 4'b1000,
        AluSra    = 4'b1001,
        AluSlt    = 4'b1010,
        AluSltu   = 4'b1011
    } aluOpT;

    typedef enum logic [1:0] {
        Src1Rs1    = 2'b00,
        Src1CsrImm = 2'b01
    } aluSrc1T;

    typedef enum logic [1:0] {
        Src2Rs2 = 2'b00,
        Src2Imm = 2'b01,
        Src2Csr = 2'b10
    } aluSrc2T;

    typedef enum logic [2:0] {
        RegAlu   = 3'b000,
        RegImm   = 3'b001,   // LUI
        RegPcImm = 3'b010,   // AUIPC
        RegPc4   = 3'b011,   // Link address
        RegCsr   = 3'b100
    } regDataSelT;

    typedef struct packed {
        aluOpT      aluOp;
        aluSrc1T    aluSrc1;
        aluSrc2T    aluSrc2;
        logic       aluToPc;
        logic       branch;
        logic [1:0] loadSel;    // 0 byte, 1 half, 2 word
        logic [1:0] maskSel;    // Same size coding for stores
        logic       memToReg;
        logic       memWr;
        regDataSelT regDataSel;
        logic       regWr;
        logic       csrWr;
        logic       uext;
    } ctrlT;

endpackage

//--- controller.sv
`timescale 1ns/1ps

module controller (
    input  rvIsaPkg::instrT instr,
    input  logic            aluZero,
    output rvCtrlPkg::ctrlT ctrl
);

    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;

    // Shared by the register and immediate integer forms
    function automatic aluOpT intAluOp(input logic [2:0] f3, input logic alt,
                                       input logic isReg);
        case (f3)
            3'b000:  return (isReg && alt) ? AluSub : AluAdd;
            3'b001:  return AluSll;
            3'b010:  return AluSlt;
            3'b011:  return AluSltu;
            3'b100:  return AluXor;
            3'b101:  return alt ? AluSra : AluSrl;
            3'b110:  return AluOr;
            default: return AluAnd;
        endcase
    endfunction

    assign opcode   = instr.r.opcode[6:2];
    assign funct3   = instr.r.funct3;
    assign funct7b5 = instr.r.funct7[5];

    always_comb begin
        ctrl.aluOp      = AluAdd;
        ctrl.aluSrc1    = Src1Rs1;
        ctrl.aluSrc2    = Src2Rs2;
        ctrl.aluToPc    = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.loadSel    = funct3[1:0];
        ctrl.maskSel    = funct3[1:0];
        ctrl.memToReg   = 1'b0;
        ctrl.memWr      = 1'b0;
        ctrl.regDataSel = RegAlu;
        ctrl.regWr      = 1'b0;
        ctrl.csrWr      = 1'b0;
        ctrl.uext       = funct3[2];

        case (opcode)
            OpReg: begin
                ctrl.regWr = 1'b1;
                ctrl.aluOp = intAluOp(funct3, funct7b5, 1'b1);
            end

            OpImm, OpLoad: begin
                ctrl.aluSrc2 = Src2Imm;
                ctrl.regWr   = 1'b1;
                if (opcode == OpImm) begin
                    ctrl.aluOp = intAluOp(funct3, funct7b5, 1'b0);
                end else begin
                    ctrl.memToReg = 1'b1;   // Address is rs1 plus offset
                end
            end

            OpJalr: begin
                ctrl.aluSrc2    = Src2Imm;
                ctrl.aluToPc    = 1'b1;
                ctrl.branch     = 1'b1;
                ctrl.regDataSel = RegPc4;
                ctrl.regWr      = 1'b1;
            end

            OpStore: begin
                ctrl.aluSrc2 = Src2Imm;
                ctrl.memWr   = 1'b1;
            end

            // SLT and SLTU give 1 on less than, so zero means not taken for BLT
            OpBranch: begin
                case (funct3)
                    3'b000: begin
                        ctrl.aluOp  = AluSub;
                        ctrl.branch = aluZero;      // BEQ
                    end
                    3'b001: begin
                        ctrl.aluOp  = AluSub;
                        ctrl.branch = ~aluZero;     // BNE
                    end
                    3'b100: begin
                        ctrl.aluOp  = AluSlt;
                        ctrl.branch = ~aluZero;     // BLT
                    end
                    3'b101: begin
                        ctrl.aluOp  = AluSlt;
                        ctrl.branch = aluZero;      // BGE
                    end
                    3'b110: begin
                        ctrl.aluOp  = AluSltu;
                        ctrl.branch = ~aluZero;     // BLTU
                    end
                    3'b111: begin
                        ctrl.aluOp  = AluSltu;
                        ctrl.branch = aluZero;      // BGEU
                    end
                    default: ctrl.branch = 1'b0;    // Reserved encodings
                endcase
            end

            OpLui, OpAuipc: begin
                ctrl.regDataSel = (opcode == OpLui) ? RegImm : RegPcImm;
                ctrl.regWr      = 1'b1;
            end

            OpJal: begin
                ctrl.branch     = 1'b1;
                ctrl.regDataSel = RegPc4;
                ctrl.regWr      = 1'b1;
            end

            OpFence: ctrl.regWr = 1'b0;             // Treated as a no-op

            OpSystem: begin
                // ECALL, EBREAK and the reserved funct3 of 4 stay no-ops
                if (funct3[1:0] != 2'b00) begin
                    ctrl.regDataSel = RegCsr;
                    ctrl.regWr      = 1'b1;
                    ctrl.csrWr      = 1'b1;
                    ctrl.aluSrc1    = funct3[2] ? Src1CsrImm : Src1Rs1;
                    ctrl.aluSrc2    = Src2Csr;
                    case (funct3[1:0])
                        2'b01:   ctrl.aluOp = AluPass;      // CSRRW(I)
                        2'b10:   ctrl.aluOp = AluOr;        // CSRRS(I)
                        default: ctrl.aluOp = AluAndNot;    // CSRRC(I)
                    endcase
                end
            end

            default: ctrl.regWr = 1'b0;             // Unknown opcode does nothing
        endcase
    end

    // A store never writes back, across every decoded form
    always_comb begin
        noStoreWriteback: assert final (!(ctrl.memWr && ctrl.regWr))
            else $error("store decoded together with a register write");
    end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  rvCtrlPkg::aluOpT              op,
    input  logic [rvIsaPkg::XLen-1:0]     a,
    input  logic [rvIsaPkg::XLen-1:0]     b,
    output logic [rvIsaPkg::XLen-1:0]     result,
    output logic                          zero
);

    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic [ShamtW-1:0] shamt;

    assign shamt = b[ShamtW-1:0];

    always_comb begin
        case (op)
            AluPass:   result = a;                 // CSR write value
            AluAdd:    result = a + b;
            AluSub:    result = a - b;
            AluAnd:    result = a & b;
            AluAndNot: result = b & ~a;            // Clears bits of the CSR
            AluOr:     result = a | b;
            AluXor:    result = a ^ b;
            AluSll:    result = a << shamt;
            AluSrl:    result = a >> shamt;
            AluSra:    result = $signed(a) >>> shamt;
            AluSlt:    result = {{(XLen-1){1'b0}}, $signed(a) < $signed(b)};
            AluSltu:   result = {{(XLen-1){1'b0}}, a < b};
            default:   result = '0;
        endcase
    end

    // Branch decisions rely on this flag
    assign zero = (result == '0);

endmodule

//--- immGen.sv
`timescale 1ns/1ps

module immGen (
    input  rvIsaPkg::instrT           instr,
    output logic [rvIsaPkg::XLen-1:0] imm
);

    import rvIsaPkg::*;

    always_comb begin
        case (instr.r.opcode[6:2])
            OpImm, OpLoad, OpJalr:
                imm = {{(XLen-12){instr.i.imm[11]}}, instr.i.imm};
            OpStore:
                imm = {{(XLen-12){instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            OpBranch:
                imm = {{(XLen-12){instr.b.imm12}}, instr.b.imm11, instr.b.imm10to5,
                       instr.b.imm4to1, 1'b0};
            OpLui, OpAuipc:
                imm = {instr.u.imm, 12'h000};   // Upper 20 bits
            OpJal:
                imm = {{(XLen-20){instr.j.imm20}}, instr.j.imm19to12, instr.j.imm11,
                       instr.j.imm10to1, 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic [4:0]                rs1Addr,
    input  logic [4:0]                rs2Addr,
    output logic [rvIsaPkg::XLen-1:0] rs1Data,
    output logic [rvIsaPkg::XLen-1:0] rs2Data,
    input  logic                      we,
    input  logic [4:0]                rdAddr,
    input  logic [rvIsaPkg::XLen-1:0] rdData
);

    import rvIsaPkg::*;

    logic [XLen-1:0] regs [32];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

    x0Stable: assert property (@(posedge clk) disable iff (!arstN)
        we && rdAddr == 5'd0 |=> $stable(regs[0]))
        else $error("write to x0 changed the stored value");

endmodule

//--- csrFile.sv
`timescale 1ns/1ps

module csrFile (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic [11:0]               csrAddr,
    input  logic                      we,
    input  logic [rvIsaPkg::XLen-1:0] wdata,
    output logic [rvIsaPkg::XLen-1:0] rdata
);

    import rvIsaPkg::*;

    logic [XLen-1:0] mtvec, mscratch, mepc, mcause;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (we) begin
            case (csrAddr)
                CsrMtvec:    mtvec    <= wdata;
                CsrMscratch: mscratch <= wdata;
                CsrMepc:     mepc     <= wdata;
                CsrMcause:   mcause   <= wdata;
                default:     ;                  // Unmapped, write dropped
            endcase
        end
    end

    always_comb begin
        case (csrAddr)
            CsrMtvec:    rdata = mtvec;
            CsrMscratch: rdata = mscratch;
            CsrMepc:     rdata = mepc;
            CsrMcause:   rdata = mcause;
            default:     rdata = '0;
        endcase
    end

endmodule

//--- loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit (
    input  rvCtrlPkg::ctrlT           ctrl,
    input  logic [1:0]                addr,        // Byte offset within the word
    input  logic [rvIsaPkg::XLen-1:0] storeData,
    input  logic [rvIsaPkg::XLen-1:0] memRdata,
    output logic [rvIsaPkg::XLen-1:0] memWdata,
    output logic [3:0]                memBe,
    output logic [rvIsaPkg::XLen-1:0] loadData
);

    import rvIsaPkg::*;

    logic [XLen-1:0] shifted;
    logic [3:0]      beRaw;

    always_comb begin
        case (ctrl.maskSel)
            2'b00: begin
                memWdata = {4{storeData[7:0]}};     // Byte on every lane
                beRaw    = 4'b0001 << addr;
            end
            2'b01: begin
                memWdata = {2{storeData[15:0]}};
                beRaw    = 4'b0011 << {addr[1], 1'b0};
            end
            default: begin
                memWdata = storeData;
                beRaw    = 4'b1111;
            end
        endcase
    end

    assign memBe = ctrl.memWr ? beRaw : 4'b0000;

    assign shifted = memRdata >> {addr, 3'b000};

    always_comb begin
        case (ctrl.loadSel)
            2'b00:   loadData = {{(XLen-8){~ctrl.uext & shifted[7]}}, shifted[7:0]};
            2'b01:   loadData = {{(XLen-16){~ctrl.uext & shifted[15]}}, shifted[15:0]};
            default: loadData = shifted;            // LW
        endcase
    end

    // Lanes are only enabled by a decoded store
    always_comb begin
        beOnlyOnStore: assert final (ctrl.memWr || memBe == 4'b0000)
            else $error("byte enables active without a store");
    end

endmodule

//--- rvCore.sv
`timescale 1ns/1ps

module rvCore (
    input  logic                      clk,
    input  logic                      arstN,
    output logic [rvIsaPkg::XLen-1:0] imemAddr,
    input  logic [rvIsaPkg::XLen-1:0] imemRdata,
    output logic [rvIsaPkg::XLen-1:0] dmemAddr,
    output logic [rvIsaPkg::XLen-1:0] dmemWdata,
    output logic [3:0]                dmemBe,
    input  logic [rvIsaPkg::XLen-1:0] dmemRdata
);

    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    instrT           instr;
    ctrlT            ctrl;
    ctrlT            lsuCtrl;
    logic [XLen-1:0] pc, pcNext, imm, csrImm;
    logic [XLen-1:0] rs1Data, rs2Data, aluA, aluB, aluResult;
    logic [XLen-1:0] csrRdata, loadData, rdData;
    logic            aluZero;

    assign instr    = imemRdata;
    assign imemAddr = pc;
    assign dmemAddr = aluResult;
    assign csrImm   = {{(XLen-5){1'b0}}, instr.i.rs1};

    controller uController (.instr(instr), .aluZero(aluZero), .ctrl(ctrl));

    immGen uImmGen (.instr(instr), .imm(imm));

    always_comb begin
        aluA = (ctrl.aluSrc1 == Src1CsrImm) ? csrImm : rs1Data;
        case (ctrl.aluSrc2)
            Src2Imm: aluB = imm;
            Src2Csr: aluB = csrRdata;               // Old CSR value
            default: aluB = rs2Data;
        endcase
    end

    alu uAlu (.op(ctrl.aluOp), .a(aluA), .b(aluB), .result(aluResult), .zero(aluZero));

    always_comb begin
        if (ctrl.memToReg) begin
            rdData = loadData;
        end else begin
            case (ctrl.regDataSel)
                RegImm:   rdData = imm;
                RegPcImm: rdData = pc + imm;
                RegPc4:   rdData = pc + 32'd4;
                RegCsr:   rdData = csrRdata;
                default:  rdData = aluResult;
            endcase
        end
    end

    regFile uRegFile (
        .clk(clk), .arstN(arstN),
        .rs1Addr(instr.r.rs1), .rs2Addr(instr.r.rs2),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .we(ctrl.regWr), .rdAddr(instr.r.rd), .rdData(rdData)
    );

    csrFile uCsrFile (
        .clk(clk), .arstN(arstN), .csrAddr(instr.i.imm),
        .we(ctrl.csrWr), .wdata(aluResult), .rdata(csrRdata)
    );

    // No store may reach memory while the core is held in reset
    always_comb begin
        lsuCtrl       = ctrl;
        lsuCtrl.memWr = ctrl.memWr & arstN;
    end

    loadStoreUnit uLsu (
        .ctrl(lsuCtrl), .addr(aluResult[1:0]), .storeData(rs2Data),
        .memRdata(dmemRdata), .memWdata(dmemWdata), .memBe(dmemBe), .loadData(loadData)
    );

    always_comb begin
        if (ctrl.aluToPc) begin
            pcNext = {aluResult[XLen-1:1], 1'b0};   // JALR target
        end else if (ctrl.branch) begin
            pcNext = pc + imm;
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= ResetPc;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

//--- rvCoreChecker.sv
`timescale 1ns/1ps

module rvCoreChecker (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic [rvIsaPkg::XLen-1:0] imemAddr,
    input  logic [rvIsaPkg::XLen-1:0] imemRdata,
    input  logic [rvIsaPkg::XLen-1:0] dmemAddr,
    input  logic [rvIsaPkg::XLen-1:0] dmemWdata,
    input  logic [3:0]                dmemBe,
    output int                        errorCount,
    output logic                      done
);

    import rvIsaPkg::*;

    localparam logic [31:0] SelfLoop = 32'h0000_006f;   // jal x0, 0

    typedef struct packed {
        logic [31:0] nextPc;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic        memOp;
        logic        regWe;
        logic [4:0]  rd;
        logic [31:0] rdVal;
        logic        csrWe;
        logic [11:0] csrAddr;
        logic [31:0] csrVal;
    } stepT;

    logic [31:0] pc;
    logic [31:0] regs [32];
    logic [31:0] csrs [4];
    logic [31:0] mem [256];
    int          errors = 0;
    logic        loopSeen = 1'b0;

    assign errorCount = errors;
    assign done       = loopSeen;

    function automatic logic [31:0] fillWord(input logic [7:0] idx);
        return {idx, idx ^ 8'hc3, ~idx, idx + 8'h5a};
    endfunction

    function automatic logic [31:0] laneMask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    function automatic logic csrMapped(input logic [11:0] addr);
        return addr == CsrMtvec || addr == CsrMscratch || addr == CsrMepc || addr == CsrMcause;
    endfunction

    function automatic logic [1:0] csrSlot(input logic [11:0] addr);
        case (addr)
            CsrMtvec:    return 2'd0;
            CsrMscratch: return 2'd1;
            CsrMepc:     return 2'd2;
            default:     return 2'd3;
        endcase
    endfunction

    function automatic logic [31:0] intOp(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // One instruction against the shadow state
    function automatic stepT refStep(input instrT w, input logic [31:0] pcIn);
        stepT        s;
        logic [2:0]  f3;
        logic        taken;
        logic [31:0] a, b, immI, immS, immB, immJ, ea, word, old, src;
        f3   = w.r.funct3;
        a    = regs[w.r.rs1];
        b    = regs[w.r.rs2];
        immI = {{20{w[31]}}, w[31:20]};
        immS = {{20{w[31]}}, w[31:25], w[11:7]};
        immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        s        = '0;
        s.nextPc = pcIn + 32'd4;
        s.rd     = w.r.rd;
        case (w.r.opcode[6:2])
            OpReg: begin
                s.regWe = 1'b1;
                s.rdVal = intOp(f3, w[30], a, b);
            end
            OpImm: begin
                s.regWe = 1'b1;
                s.rdVal = intOp(f3, (f3 == 3'b101) & w[30], a, immI);   // SRAI only
            end
            OpLoad: begin
                ea      = a + immI;
                word    = mem[ea[9:2]] >> {ea[1:0], 3'b000};
                s.memOp = 1'b1;
                s.addr  = ea;
                s.regWe = 1'b1;
                case (f3)
                    3'b000:  s.rdVal = {{24{word[7]}}, word[7:0]};
                    3'b100:  s.rdVal = {24'd0, word[7:0]};
                    3'b001:  s.rdVal = {{16{word[15]}}, word[15:0]};
                    3'b101:  s.rdVal = {16'd0, word[15:0]};
                    default: s.rdVal = word;
                endcase
            end
            OpStore: begin
                ea      = a + immS;
                s.memOp = 1'b1;
                s.addr  = ea;
                s.wdata = b << {ea[1:0], 3'b000};
                case (f3[1:0])
                    2'b00:   s.be = 4'b0001 << ea[1:0];
                    2'b01:   s.be = 4'b0011 << ea[1:0];
                    default: s.be = 4'b1111;
                endcase
            end
            OpBranch: begin
                case (f3)
                    3'b000:  taken = a == b;
                    3'b001:  taken = a != b;
                    3'b100:  taken = $signed(a) < $signed(b);
                    3'b101:  taken = $signed(a) >= $signed(b);
                    3'b110:  taken = a < b;
                    3'b111:  taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken) s.nextPc = pcIn + immB;
            end
            OpJal: begin
                s.regWe  = 1'b1;
                s.rdVal  = pcIn + 32'd4;
                s.nextPc = pcIn + immJ;
            end
            OpJalr: begin
                s.regWe  = 1'b1;
                s.rdVal  = pcIn + 32'd4;
                s.nextPc = (a + immI) & ~32'd1;
            end
            OpLui: begin
                s.regWe = 1'b1;
                s.rdVal = {w[31:12], 12'd0};
            end
            OpAuipc: begin
                s.regWe = 1'b1;
                s.rdVal = pcIn + {w[31:12], 12'd0};
            end
            OpSystem: begin
                if (f3[1:0] != 2'b00) begin                 // ECALL changes nothing
                    old       = csrMapped(w.i.imm) ? csrs[csrSlot(w.i.imm)] : 32'd0;
                    src       = f3[2] ? {27'd0, w.i.rs1} : a;
                    s.regWe   = 1'b1;
                    s.rdVal   = old;
                    s.csrWe   = csrMapped(w.i.imm);
                    s.csrAddr = w.i.imm;
                    case (f3[1:0])
                        2'b01:   s.csrVal = src;
                        2'b10:   s.csrVal = old | src;
                        default: s.csrVal = old & ~src;
                    endcase
                end
            end
            default: ;                                      // FENCE
        endcase
        return s;
    endfunction

    task automatic expectEq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin : compareStep
        stepT        e;
        logic [31:0] mask;
        if (!arstN) begin
            pc = ResetPc;
            for (int i = 0; i < 32; i++) begin
                regs[i[4:0]] = 32'd0;
            end
            for (int i = 0; i < 4; i++) begin
                csrs[i[1:0]] = 32'd0;
            end
            for (int i = 0; i < 256; i++) begin
                mem[i[7:0]] = fillWord(i[7:0]);
            end
            expectEq("dmemBe", 32'd0, {28'd0, dmemBe});
        end else if (!loopSeen) begin
            e    = refStep(imemRdata, pc);
            mask = laneMask(e.be);
            expectEq("imemAddr", pc, imemAddr);
            expectEq("dmemBe", {28'd0, e.be}, {28'd0, dmemBe});
            if (e.memOp) expectEq("dmemAddr", e.addr, dmemAddr);
            if (e.be != 4'b0000) expectEq("dmemWdata", e.wdata & mask, dmemWdata & mask);

            if (e.regWe && e.rd != 5'd0) regs[e.rd] = e.rdVal;
            if (e.csrWe) csrs[csrSlot(e.csrAddr)] = e.csrVal;
            mem[e.addr[9:2]] = (mem[e.addr[9:2]] & ~mask) | (e.wdata & mask);
            pc = e.nextPc;
            if (imemRdata == SelfLoop) loopSeen = 1'b1;
        end
    end

endmodule

//--- rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb;

    import rvIsaPkg::*;

    localparam logic [31:0] Seed = 32'h49e9_3ce5;
    localparam logic [31:0] Nop = 32'h0000_0013;       // addi x0, x0, 0
    localparam logic [7:0]  BodyWords = 8'd196;
    localparam logic [7:0]  LoopIdx = 8'd200;
    localparam int          MaxCycles = 2000;

    logic            clk;
    logic            arstN;
    logic [XLen-1:0] imemAddr, imemRdata, dmemAddr, dmemWdata, dmemRdata;
    logic [3:0]      dmemBe;
    logic [31:0]     beMask;
    logic [31:0]     imem [256];
    logic [31:0]     dmem [256];
    logic            hit [256];                          // Words that a branch or JAL lands on
    int              errorCount;
    logic            done;
    int              timeouts;
    int              cycles;

    always #10 clk = ~clk;

    assign imemRdata = imem[imemAddr[9:2]];
    assign dmemRdata = dmem[dmemAddr[9:2]];
    assign beMask    = {{8{dmemBe[3]}}, {8{dmemBe[2]}}, {8{dmemBe[1]}}, {8{dmemBe[0]}}};

    always @(posedge clk) begin
        if (dmemBe != 4'b0000) begin
            dmem[dmemAddr[9:2]] <= (dmem[dmemAddr[9:2]] & ~beMask) | (dmemWdata & beMask);
        end
    end

    rvCore rvCore_inst (
        .clk(clk), .arstN(arstN),
        .imemAddr(imemAddr), .imemRdata(imemRdata),
        .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemBe(dmemBe), .dmemRdata(dmemRdata)
    );

    rvCoreChecker coreChecker (
        .clk(clk), .arstN(arstN),
        .imemAddr(imemAddr), .imemRdata(imemRdata),
        .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemBe(dmemBe),
        .errorCount(errorCount), .done(done)
    );

    // Same pattern as the shadow copy in the checker
    function automatic logic [31:0] fillWord(input logic [7:0] idx);
        return {idx, idx ^ 8'hc3, ~idx, idx + 8'h5a};
    endfunction

    function automatic logic [11:0] alignedOffset(input logic [31:0] raw, input logic [1:0] size);
        case (size)
            2'b10:   return {2'b00, raw[9:2], 2'b00};
            2'b01:   return {2'b00, raw[9:1], 1'b0};
            default: return {2'b00, raw[9:0]};
        endcase
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] im, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], 7'h63};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] im, input logic [4:0] rd);
        return {im[20], im[10:1], im[11], im[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [11:0] csrPick(input logic [31:0] n);
        case (n % 5)
            0:       return CsrMtvec;
            1:       return CsrMscratch;
            2:       return CsrMepc;
            3:       return CsrMcause;
            default: return 12'h7c0;                     // Not mapped
        endcase
    endfunction

    task automatic buildProgram();
        logic [7:0]  idx;
        logic [31:0] r;
        logic [31:0] n;
        logic [31:0] off;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = Nop;
            hit[i[7:0]]  = 1'b0;
        end
        // Sits at the PC during reset so its byte enables must stay masked
        imem[0] = {7'd0, 5'd0, 5'd0, 3'b010, 5'd0, 7'h23};  // sw x0, 0(x0)
        idx = 8'd1;
        while (idx < BodyWords) begin
            r   = $urandom;
            n   = $urandom;
            off = $urandom % 1024;
            rd  = r[11:7];
            rs1 = r[19:15];
            rs2 = r[24:20];
            f3  = r[14:12];
            case ($urandom % 16)
                0, 1, 2, 3: begin
                    imem[idx] = {1'b0, (f3 == 3'b000 || f3 == 3'b101) & r[30], 5'd0,
                                 rs2, rs1, f3, rd, 7'h33};
                end
                4, 5, 6: begin
                    imm = r[31:20];
                    if (f3 == 3'b001) imm = {7'd0, r[24:20]};
                    if (f3 == 3'b101) imm = {1'b0, r[30], 5'd0, r[24:20]};
                    imem[idx] = {imm, rs1, f3, rd, 7'h13};
                end
                7: begin
                    n  = n % 5;
                    n  = (n < 3) ? n : n + 1;            // LB LH LW LBU LHU
                    f3 = n[2:0];
                    imm = alignedOffset(off, f3[1:0]);
                    imem[idx] = {imm, 5'd0, f3, rd, 7'h03};
                end
                8, 9: begin
                    n   = n % 3;
                    f3  = n[2:0];
                    imm = alignedOffset(off, f3[1:0]);
                    imem[idx] = {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23};
                end
                10: begin
                    n   = n % 6;
                    n   = (n < 2) ? n : n + 2;
                    off = (off % 4 + 1) * 4;
                    hit[idx + off[9:2]] = 1'b1;
                    imem[idx] = encB(off[12:0], rs2, rs1, n[2:0]);
                end
                11: begin
                    off = (off % 4 + 1) * 4;
                    hit[idx + off[9:2]] = 1'b1;
                    imem[idx] = encJ(off[20:0], rd);
                end
                12: begin
                    // Target skips one word and has bit 0 set
                    if (idx + 8'd1 < BodyWords && !hit[idx + 8'd1]) begin
                        rs1 = rs1 | 5'd1;
                        off = {22'd0, idx, 2'b00} + 32'd13;
                        imem[idx] = {off[11:0], 5'd0, 3'b000, rs1, 7'h13};
                        idx = idx + 8'd1;
                        imem[idx] = {12'd0, rs1, 3'b000, rd, 7'h67};
                    end
                end
                13: imem[idx] = {r[31:12], rd, r[0] ? 7'h37 : 7'h17};
                14: begin
                    off = off % 6;
                    off = (off < 3) ? off + 1 : off + 2;
                    imem[idx] = {csrPick(n), rs1, off[2:0], rd, 7'h73};
                end
                15: imem[idx] = r[0] ? 32'h0ff0_000f : 32'h0000_0073;   // FENCE or ECALL
            endcase
            idx = idx + 8'd1;
        end
        imem[LoopIdx] = encJ(21'd0, 5'd0);
    endtask

    initial begin
        void'($urandom(Seed));
        clk      = 1'b0;
        arstN    = 1'b0;
        timeouts = 0;
        for (int i = 0; i < 256; i++) begin
            dmem[i[7:0]] = fillWord(i[7:0]);
        end
        buildProgram();

        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
        end
        #2 arstN = 1'b1;

        cycles = 0;
        while (!done && cycles < MaxCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout: the program did not reach its final loop in %0d cycles", MaxCycles);
            timeouts++;
        end

        $display("Errors: %0d mismatches, %0d timeouts", errorCount, timeouts);
        if (errorCount == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
rvIsaPkg.sv
rvCtrlPkg.sv
controller.sv
alu.sv
immGen.sv
regFile.sv
csrFile.sv
loadStoreUnit.sv
rvCore.sv
rvCoreChecker.sv
rvCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the core and its testbench with Verilator, run it, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rvCoreTb -f files.f -o rvCoreSim
./obj_dir/rvCoreSim | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
